/* sources.f */
+incdir+.
cache_pkg.sv
line_write_stage.sv
way_data_ram.sv
line_read_select.sv
line_cache_data.sv
cache_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the cache data array testbench with Verilator and runs it.
# Exits non-zero unless the simulation log holds the pass line.
set -u

cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator was not found on PATH"
  exit 1
fi

verilator --binary --timing --assert -Wno-fatal \
  --top-module cache_tb -f sources.f -Mdir obj_dir -o cache_sim \
  > "$build_log" 2>&1
build_status=$?
if [ "$build_status" -ne 0 ]; then
  echo "build failed with status $build_status, see $build_log"
  exit 1
fi

./obj_dir/cache_sim > "$sim_log" 2>&1
run_status=$?
if [ "$run_status" -ne 0 ]; then
  echo "simulation exited with status $run_status, see $sim_log"
  exit 1
fi

if grep -qx "NO ERRORS" "$sim_log"; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed, see $sim_log"
  exit 1
fi

/* cache_tb.sv */
//**************************************
// self-checking testbench for line_cache_data.
// expected lines come from a model array of raw lines.
// writes are followed by one idle cycle before the next read.
//**************************************
`include "cache_defines.svh"

module cache_tb;

  import cache_pkg::*;

  typedef struct packed {
    logic is_read;
    logic [2:0] test_id;
    set_idx_t set_idx;
    way_idx_t way;
    way_mask_t hit;
    line_t data;
    line_t exp_data;
    word_err_t exp_err;
  } row_t;

  logic clk;
  logic rst;
  logic wr_en;
  set_idx_t wr_set;
  way_idx_t wr_way;
  line_t wr_data;
  logic rd_en;
  set_idx_t rd_set;
  way_mask_t rd_hit_way;
  logic ready;
  logic rd_valid;
  rd_rsp_t rd_rsp;

  row_t rows [$];
  line_t model [`CACHE_WAYS][`CACHE_SETS];
  int pend_q [$];
  int issue_q [$];
  int cycle = 0;
  int checks = 0;
  int errors = 0;
  logic rows_ready = 1'b0;

  line_cache_data dut (
    .clk (clk),
    .rst (rst),
    .wr_en (wr_en),
    .wr_set (wr_set),
    .wr_way (wr_way),
    .wr_data (wr_data),
    .rd_en (rd_en),
    .rd_set (rd_set),
    .rd_hit_way (rd_hit_way),
    .ready (ready),
    .rd_valid (rd_valid),
    .rd_rsp (rd_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  task automatic check_line(input string name, input line_t got, input line_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] t=%0t %s: expected %h, got %h", $time, name, exp, got);
    end
  endtask

  task automatic check_err(input string name, input word_err_t got, input word_err_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] t=%0t %s: expected %b, got %b", $time, name, exp, got);
    end
  endtask

  task automatic check_cycles(input string name, input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("[ERROR] t=%0t %s: expected %0d, got %0d", $time, name, exp, got);
    end
  endtask

  function automatic line_t rand_line();
    line_t l;
    for (int i = 0; i < `CACHE_LINE_WORDS * `CACHE_WORD_BITS / 32; i++) begin
      l[i*32 +: 32] = $urandom();
    end
    return l;
  endfunction

  // data is the OR of the hit lines. the error of a word is the xor of the
  // OR of the hit ways' parity words, whose parity bit is the xor of the word.
  function automatic void expect_read(input set_idx_t s, input way_mask_t m,
                                      output line_t d, output word_err_t e);
    pword_t merged;
    word_t wd;
    d = '0;
    e = '0;
    for (int i = 0; i < `CACHE_WAYS; i++) begin
      if (m[i]) d = d | model[i][s];
    end
    for (int w = 0; w < `CACHE_LINE_WORDS; w++) begin
      merged = '0;
      for (int i = 0; i < `CACHE_WAYS; i++) begin
        if (m[i]) begin
          wd = model[i][s][w*`CACHE_WORD_BITS +: `CACHE_WORD_BITS];
          merged = merged | {^wd, wd};
        end
      end
      e[w] = ^merged;
    end
  endfunction

  task automatic add_write(input int t, input set_idx_t s, input way_idx_t w, input line_t d);
    row_t r;
    r = '0;
    r.test_id = t[2:0];
    r.set_idx = s;
    r.way = w;
    r.data = d;
    model[w][s] = d;
    rows.push_back(r);
  endtask

  task automatic add_read(input int t, input set_idx_t s, input way_mask_t m);
    row_t r;
    line_t d;
    word_err_t e;
    r = '0;
    r.is_read = 1'b1;
    r.test_id = t[2:0];
    r.set_idx = s;
    r.hit = m;
    expect_read(s, m, d, e);
    r.exp_data = d;
    r.exp_err = e;
    rows.push_back(r);
  endtask

  task automatic build_table();
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      for (int s = 0; s < `CACHE_SETS; s++) begin
        model[w][s] = '0;
      end
    end
    // test 1 finds every set of every way clear after init.
    for (int s = 0; s < `CACHE_SETS; s++) begin
      for (int w = 0; w < `CACHE_WAYS; w++) begin
        add_read(1, set_idx_t'(s), way_mask_t'(1 << w));
      end
    end
    // test 2 writes single ways and reads them back.
    for (int i = 0; i < 8; i++) begin
      add_write(2, set_idx_t'(4*i + 1), way_idx_t'(i % 4), rand_line());
    end
    for (int i = 0; i < 8; i++) begin
      add_read(2, set_idx_t'(4*i + 1), way_mask_t'(1 << (i % 4)));
    end
    // test 3 overwrites one way of a full set.
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      add_write(3, 5'd10, way_idx_t'(w), rand_line());
    end
    add_write(3, 5'd11, 2'd3, rand_line());
    add_write(3, 5'd10, 2'd2, rand_line());
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      add_read(3, 5'd10, way_mask_t'(1 << w));
    end
    add_read(3, 5'd11, 4'b1000);
    add_read(3, 5'd11, 4'b0100);
    // a zero hit mask is a miss in test 4.
    add_read(4, 5'd1, 4'b0000);
    add_read(4, 5'd10, 4'b0000);
    add_read(4, 5'd31, 4'b0000);
    // test 5 merges the lines of several hit bits.
    add_read(5, 5'd10, 4'b0011);
    add_read(5, 5'd10, 4'b0101);
    add_read(5, 5'd10, 4'b1110);
    add_read(5, 5'd10, 4'b1111);
    add_read(5, 5'd1, 4'b1111);
    add_read(5, 5'd11, 4'b1001);
    // test 6 issues back-to-back reads in reverse order.
    for (int i = 7; i >= 0; i--) begin
      add_read(6, set_idx_t'(4*i + 1), way_mask_t'(1 << (i % 4)));
    end
  endtask

  function automatic string test_title(input logic [2:0] t);
    case (t)
      3'd1: return "clear after init";
      3'd2: return "write and read back";
      3'd3: return "overwrite one way";
      3'd4: return "zero hit mask";
      3'd5: return "multi-way hit";
      default: return "back-to-back reads";
    endcase
  endfunction

  task automatic apply_row(input int i);
    row_t r;
    r = rows[i];
    @(negedge clk);
    wr_en = 1'b0;
    rd_en = 1'b0;
    if (r.is_read) begin
      rd_en = 1'b1;
      rd_set = r.set_idx;
      rd_hit_way = r.hit;
      pend_q.push_back(i);
      issue_q.push_back(cycle);
    end else begin
      wr_en = 1'b1;
      wr_set = r.set_idx;
      wr_way = r.way;
      wr_data = r.data;
      @(negedge clk);
      wr_en = 1'b0;
    end
  endtask

  task automatic drain_reads();
    @(negedge clk);
    wr_en = 1'b0;
    rd_en = 1'b0;
    while (pend_q.size() != 0) @(negedge clk);
  endtask

  // the response monitor samples on the falling edge.
  always @(negedge clk) begin
    int idx;
    int issued;
    if (!rst && rd_valid) begin
      if (pend_q.size() == 0) begin
        errors++;
        $display("rd_valid was high at t=%0t with no read outstanding", $time);
      end else begin
        idx = pend_q.pop_front();
        issued = issue_q.pop_front();
        check_cycles("rd_valid latency", cycle - issued, 2);
        check_line("rd_rsp.data", rd_rsp.data, rows[idx].exp_data);
        check_err("rd_rsp.err", rd_rsp.err, rows[idx].exp_err);
      end
    end else if (pend_q.size() != 0 && cycle - issue_q[0] > 2) begin
      errors++;
      idx = pend_q.pop_front();
      issued = issue_q.pop_front();
      $display("no response for read of set %0d issued at cycle %0d",
               rows[idx].set_idx, issued);
    end
  end

  initial begin
    int limit;
    wait (rows_ready);
    limit = rows.size() * 4 + `CACHE_SETS + 16 + 64;
    repeat (limit) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", limit);
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin
    int start;
    int t_checks;
    int t_errors;
    rst = 1'b1;
    wr_en = 1'b0;
    wr_set = '0;
    wr_way = '0;
    wr_data = '0;
    rd_en = 1'b0;
    rd_set = '0;
    rd_hit_way = '0;
    t_checks = 0;
    t_errors = 0;
    void'($urandom(32'h4197));
    build_table();
    rows_ready = 1'b1;

    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    start = cycle;
    while (!ready) @(negedge clk);
    check_cycles("ready latency", cycle - start, `CACHE_SETS + 1);

    for (int i = 0; i < rows.size(); i++) begin
      if (i == 0 || rows[i].test_id != rows[i-1].test_id) begin
        t_checks = checks;
        t_errors = errors;
      end
      apply_row(i);
      if (i == rows.size() - 1 || rows[i+1].test_id != rows[i].test_id) begin
        drain_reads();
        $display("test %0d (%s): %0d checks, %0d errors", rows[i].test_id,
                 test_title(rows[i].test_id), checks - t_checks, errors - t_errors);
      end
    end

    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* line_cache_data.sv */
//**************************************
// data array of a set-associative cache.
// hits come in as a way mask, responses
// return two cycles after rd_en.
//**************************************
`include "cache_defines.svh"

module line_cache_data (
  input logic clk,
  input logic rst,
  input logic wr_en,
  input cache_pkg::set_idx_t wr_set,
  input cache_pkg::way_idx_t wr_way,
  input cache_pkg::line_t wr_data,
  input logic rd_en,
  input cache_pkg::set_idx_t rd_set,
  input cache_pkg::way_mask_t rd_hit_way,
  output logic ready,
  output logic rd_valid,
  output cache_pkg::rd_rsp_t rd_rsp
);

  import cache_pkg::*;

  ram_wr_t ram_wr;
  pline_t [`CACHE_WAYS-1:0] way_lines;
  logic rd_en_q;
  way_mask_t hit_way_q;

  line_write_stage u_write (
    .clk (clk),
    .rst (rst),
    .wr_en (wr_en),
    .wr_set (wr_set),
    .wr_way (wr_way),
    .wr_data (wr_data),
    .ready (ready),
    .ram_wr (ram_wr)
  );

  for (genvar w = 0; w < `CACHE_WAYS; w++) begin : g_way
    way_data_ram #(.WAY(w)) u_ram (
      .clk (clk),
      .rst (rst),
      .rd_en (rd_en),
      .rd_set (rd_set),
      .ram_wr (ram_wr),
      .rd_line (way_lines[w])
    );
  end

  // the hit mask travels alongside the RAM read address.
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_en_q <= 1'b0;
    end else begin
      rd_en_q <= rd_en;
    end
    hit_way_q <= rd_hit_way;
  end

  line_read_select u_select (
    .clk (clk),
    .rst (rst),
    .rd_en_q (rd_en_q),
    .hit_way_q (hit_way_q),
    .way_lines (way_lines),
    .rd_valid (rd_valid),
    .rd_rsp (rd_rsp)
  );

  // every read gets its response exactly two cycles later.
  a_rd_latency: assert property (
    @(posedge clk) disable iff (rst)
    rd_en |-> ##2 rd_valid
  );

endmodule

/* line_read_select.sv */
//**************************************
// ORs the hit ways together, so more than
// one hit bit gives a merged line.
// a zero hit mask reads as zero, no error.
//**************************************
`include "cache_defines.svh"

module line_read_select (
  input logic clk,
  input logic rst,
  input logic rd_en_q,
  input cache_pkg::way_mask_t hit_way_q,
  input cache_pkg::pline_t [`CACHE_WAYS-1:0] way_lines,
  output logic rd_valid,
  output cache_pkg::rd_rsp_t rd_rsp
);

  import cache_pkg::*;

  localparam int PWORD_BITS = `CACHE_WORD_BITS + 1;

  pline_t hit_line;
  pword_t hit_word;
  line_t rsp_data;
  word_err_t rsp_err;

  // chained way combine as a plain OR.
  always_comb begin
    hit_line = '0;
    for (int i = 0; i < `CACHE_WAYS; i++) begin
      if (hit_way_q[i]) begin
        hit_line = hit_line | way_lines[i];
      end
    end
  end

  // odd parity over a stored word flags an error.
  always_comb begin
    hit_word = '0;
    for (int w = 0; w < `CACHE_LINE_WORDS; w++) begin
      hit_word = hit_line[w*PWORD_BITS +: PWORD_BITS];
      rsp_err[w] = ^hit_word;
      rsp_data[w*`CACHE_WORD_BITS +: `CACHE_WORD_BITS] =
        hit_word[`CACHE_WORD_BITS-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= rd_en_q;
    end
  end

  always_ff @(posedge clk) begin
    rd_rsp.data <= rsp_data;
    rd_rsp.err <= rsp_err;
  end

  // a miss returns a valid response of zero data and no error.
  a_miss_reads_zero: assert property (
    @(posedge clk) disable iff (rst)
    (rd_en_q && hit_way_q == '0) |=> (rd_valid && rd_rsp == '0)
  );

endmodule

/* way_data_ram.sv */
//**************************************
// line storage of one way.
// read address is registered, array read is combinational.
//**************************************
`include "cache_defines.svh"

module way_data_ram #(
  parameter int WAY = 0
) (
  input logic clk,
  input logic rst,
  input logic rd_en,
  input cache_pkg::set_idx_t rd_set,
  input cache_pkg::ram_wr_t ram_wr,
  output cache_pkg::pline_t rd_line
);

  import cache_pkg::*;

  pline_t mem [`CACHE_SETS];
  set_idx_t rd_addr;

  // the address holds between reads.
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_addr <= '0;
    end else if (rd_en) begin
      rd_addr <= rd_set;
    end
  end

  // this way writes only on its own mask bit.
  always_ff @(posedge clk) begin
    if (ram_wr.en && ram_wr.way_mask[WAY]) begin
      mem[ram_wr.set_idx] <= ram_wr.pline;
    end
  end

  assign rd_line = mem[rd_addr];

endmodule

/* line_write_stage.sv */
//**************************************
// clears every set of every way after reset.
// host writes are dropped while ready is low.
// one write per cycle, no back-pressure.
//**************************************
`include "cache_defines.svh"

module line_write_stage (
  input logic clk,
  input logic rst,
  input logic wr_en,
  input cache_pkg::set_idx_t wr_set,
  input cache_pkg::way_idx_t wr_way,
  input cache_pkg::line_t wr_data,
  output logic ready,
  output cache_pkg::ram_wr_t ram_wr
);

  import cache_pkg::*;

  localparam int PWORD_BITS = `CACHE_WORD_BITS + 1;

  init_state_t state;
  set_idx_t init_set;
  way_mask_t host_mask;
  pline_t host_pline;
  logic host_wr;

  // one-hot decode of the target way.
  always_comb begin
    host_mask = '0;
    host_mask[wr_way] = 1'b1;
  end

  // even parity on top of each word.
  always_comb begin
    for (int w = 0; w < `CACHE_LINE_WORDS; w++) begin
      host_pline[w*PWORD_BITS +: PWORD_BITS] =
        {^wr_data[w*`CACHE_WORD_BITS +: `CACHE_WORD_BITS],
         wr_data[w*`CACHE_WORD_BITS +: `CACHE_WORD_BITS]};
    end
  end

  assign host_wr = wr_en & ready;

  // the init sweep clears one set per cycle from set 0.
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= INIT_CLEAR;
      init_set <= '0;
      ready <= 1'b0;
    end else begin
      if (state == INIT_CLEAR) begin
        init_set <= init_set + 1'b1;
        if (init_set == set_idx_t'(`CACHE_SETS - 1)) begin
          state <= INIT_READY;
        end
      end
      // ready follows one cycle later, when the last clear lands in the RAMs.
      ready <= (state == INIT_READY);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ram_wr.en <= 1'b0;
    end else begin
      ram_wr.en <= (state == INIT_CLEAR) | host_wr;
    end
    if (state == INIT_CLEAR) begin
      ram_wr.set_idx <= init_set;
      ram_wr.way_mask <= '1;
      ram_wr.pline <= '0;
    end else begin
      ram_wr.set_idx <= wr_set;
      ram_wr.way_mask <= host_mask;
      ram_wr.pline <= host_pline;
    end
  end

  // once the sweep is done, every write targets exactly one way.
  a_host_wr_onehot: assert property (
    @(posedge clk) disable iff (rst)
    (ready && ram_wr.en) |-> $onehot(ram_wr.way_mask)
  );

endmodule

/* cache_pkg.sv */
//**************************************
// types shared by the cache data array.
// a stored word carries its parity bit as the msb.
//**************************************
`include "cache_defines.svh"

package cache_pkg;

  typedef logic [`CACHE_WORD_BITS-1:0] word_t;
  typedef logic [`CACHE_WORD_BITS:0] pword_t;

  // raw line, word 0 in the low bits.
  typedef logic [`CACHE_LINE_WORDS*`CACHE_WORD_BITS-1:0] line_t;
  // stored line, each word 65 bits with parity on top.
  typedef logic [`CACHE_LINE_WORDS*(`CACHE_WORD_BITS+1)-1:0] pline_t;

  typedef logic [`CACHE_SET_BITS-1:0] set_idx_t;
  typedef logic [$clog2(`CACHE_WAYS)-1:0] way_idx_t;
  typedef logic [`CACHE_WAYS-1:0] way_mask_t;
  typedef logic [`CACHE_LINE_WORDS-1:0] word_err_t;

  // write request from the write stage to every way RAM.
  typedef struct packed {
    logic en;
    set_idx_t set_idx;
    way_mask_t way_mask;
    pline_t pline;
  } ram_wr_t;

  // registered read response.
  typedef struct packed {
    line_t data;
    word_err_t err;
  } rd_rsp_t;

  typedef enum logic {
    INIT_CLEAR,
    INIT_READY
  } init_state_t;

endpackage

/* cache_defines.svh */
//**************************************
// sizes of the cache data array.
// CACHE_SET_BITS must equal clog2 of CACHE_SETS.
// ways must be a power of two.
//**************************************
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// associativity.
`define CACHE_WAYS 4

// sets per way, and the index width that addresses them.
`define CACHE_SETS 32
`define CACHE_SET_BITS 5

// data words in one line.
`define CACHE_LINE_WORDS 4

// data bits per word, parity not included.
`define CACHE_WORD_BITS 64

`endif
